// File: rtl/pinmux_pkg.sv
package pinmux_pkg;

   // ------------------------------
   // Bus and field types
   // ------------------------------
   typedef logic [31:0] reg_data_t;   // Register data word
   typedef logic [7:0]  reg_addr_t;   // Byte address
   typedef logic [3:0]  reg_be_t;     // Byte enables
   typedef logic [4:0]  reg_idx_t;    // Word index, addr[6:2]

   typedef logic [31:0] gpio_vec_t;   // One bit per pin
   typedef logic [9:0]  pulse_cnt_t;  // 1us prescale count
   typedef logic [1:0]  core_rst_t;   // CPU core resets

   // Serial shift engine states
   typedef enum logic [1:0]
   {
      SER_IDLE,
      SER_SHIFT,
      SER_DONE
   } ser_state_t;

   // ------------------------------
   // Register word indices
   // ------------------------------
   localparam reg_idx_t REG_CHIP_ID       = 5'd0;
   localparam reg_idx_t REG_FUSE          = 5'd1;
   localparam reg_idx_t REG_GLBL_CFG1     = 5'd2;
   localparam reg_idx_t REG_GLBL_CFG2     = 5'd3;
   localparam reg_idx_t REG_GPIO_IN       = 5'd4;
   localparam reg_idx_t REG_GPIO_OUT      = 5'd5;
   localparam reg_idx_t REG_GPIO_DIR      = 5'd6;
   localparam reg_idx_t REG_GPIO_TYPE     = 5'd7;
   localparam reg_idx_t REG_IRQ           = 5'd8;
   localparam reg_idx_t REG_GPIO_INT_CLR  = 5'd9;   // W1C alias of status
   localparam reg_idx_t REG_GPIO_INT_SET  = 5'd10;  // W1S alias of status
   localparam reg_idx_t REG_GPIO_INT_MASK = 5'd11;
   localparam reg_idx_t REG_GPIO_POS_SEL  = 5'd12;
   localparam reg_idx_t REG_GPIO_NEG_SEL  = 5'd13;
   localparam reg_idx_t REG_BIST_CTRL     = 5'd28;
   localparam reg_idx_t REG_SER_WR        = 5'd30;
   localparam reg_idx_t REG_SER_RD        = 5'd31;

   // Manufacturer 8268, 2 cores, chip 3, rev 01
   localparam reg_data_t CHIP_ID_VALUE = 32'h8268_2301;
   localparam reg_data_t FUSE_RESET    = 32'hA55A_A55A;
   localparam reg_data_t IRQ_WR_MASK   = 32'h000F_07FF;  // Bits 10:0 and 19:16

   localparam int SER_BITS = 32;  // Serial chain length

   // Merge a write word into a register, lane by lane
   function automatic reg_data_t be_merge(input reg_data_t cur, input reg_data_t nxt,
                                          input reg_be_t be);
      reg_data_t res;
      res = cur;
      for (int i = 0; i < 4; i++)
      begin
         if (be[i])
            res[i*8 +: 8] = nxt[i*8 +: 8];
      end
      return res;
   endfunction

endpackage

// File: rtl/reg_bus_slave.sv
`timescale 1ns/1ps

module reg_bus_slave import pinmux_pkg::*;
(
   input  logic      mclk,
   input  logic      h_reset_n,

   // External register bus
   input  logic      reg_cs,
   input  logic      reg_wr,
   input  reg_addr_t reg_addr,
   input  reg_data_t reg_wdata,
   input  reg_be_t   reg_be,
   output reg_data_t reg_rdata,
   output logic      reg_ack,

   // Read data back from the groups
   input  reg_data_t glbl_rdata,
   input  reg_data_t gpio_rdata,
   input  reg_data_t ser_rdata,
   input  logic      ser_sel,    // Serial access in progress
   input  logic      ser_ack,    // Shift engine finished

   // Decoded request, fanned out
   output logic      wr_en,
   output logic      rd_en,
   output logic      req_pedge,
   output reg_idx_t  reg_idx,
   output reg_data_t wdata,
   output reg_be_t   be
);

   logic      req_q;      // Request seen, not yet acked
   logic      req_d;      // One cycle later
   reg_data_t rd_merge;
   logic      non_ser_acc;

   // ------------------------------
   // Decode
   // ------------------------------
   assign reg_idx = reg_addr[6:2];       // Word index
   assign wr_en   = reg_cs & reg_wr;
   assign rd_en   = reg_cs & ~reg_wr;
   assign wdata   = reg_wdata;
   assign be      = reg_be;

   // Each group returns zero outside its own indices
   assign rd_merge = glbl_rdata | gpio_rdata | ser_rdata;

   assign non_ser_acc = reg_cs & ~ser_sel;

   // ------------------------------
   // Request edge detect
   // ------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         req_q <= 1'b0;
         req_d <= 1'b0;
      end
      else
      begin
         req_q <= reg_cs & ~reg_ack;
         req_d <= req_q;
      end
   end

   assign req_pedge = req_q & ~req_d;  // Kicks off the shift engine

   // ------------------------------
   // Read data and acknowledge
   // ------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         reg_rdata <= '0;
         reg_ack   <= 1'b0;
      end
      else if (ser_sel && ser_ack)
      begin
         reg_rdata <= rd_merge;       // Shift register from the engine
         reg_ack   <= 1'b1;
      end
      else if (non_ser_acc && !reg_ack)
      begin
         reg_rdata <= rd_merge;       // Single-cycle access
         reg_ack   <= 1'b1;
      end
      else
      begin
         reg_ack <= 1'b0;             // rdata holds
      end
   end

endmodule

// File: rtl/glbl_cfg_regs.sv
`timescale 1ns/1ps

module glbl_cfg_regs import pinmux_pkg::*;
(
   input  logic       mclk,
   input  logic       h_reset_n,
   input  logic       wr_en,
   input  reg_idx_t   reg_idx,
   input  reg_data_t  wdata,
   input  reg_be_t    be,
   input  logic       gpio_intr,
   input  logic       usb_intr,
   input  logic       i2cm_intr,
   input  logic [1:0] ext_intr_in,
   output reg_data_t  rdata,
   output reg_data_t  fuse_mhartid,
   output core_rst_t  cpu_core_rst_n,
   output logic       cpu_intf_rst_n,
   output logic       qspim_rst_n,
   output logic       sspim_rst_n,
   output logic       uart_rst_n,
   output logic       i2cm_rst_n,
   output logic       usb_rst_n,
   output pulse_cnt_t cfg_pulse_1us,
   output logic [1:0] cfg_riscv_debug_sel,
   output logic [15:0] irq_lines,
   output logic       soft_irq,
   output logic [2:0] user_irq
);

   reg_data_t fuse_q;
   reg_data_t cfg1_q;    // Soft resets
   reg_data_t cfg2_q;    // Pulse count, debug select
   reg_data_t irq_q;     // Only IRQ_WR_MASK bits kept
   reg_data_t irq_word;

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         fuse_q <= FUSE_RESET;
         cfg1_q <= '0;                // All blocks held in reset
         cfg2_q <= '0;
         irq_q  <= '0;
      end
      else if (wr_en)
      begin
         case (reg_idx)
            REG_FUSE:      fuse_q <= be_merge(fuse_q, wdata, be);
            REG_GLBL_CFG1: cfg1_q <= be_merge(cfg1_q, wdata, be);
            REG_GLBL_CFG2: cfg2_q <= be_merge(cfg2_q, wdata, be);
            REG_IRQ:       irq_q  <= be_merge(irq_q, wdata, be) & IRQ_WR_MASK;
            default:       ;
         endcase
      end
   end

   // Live interrupt inputs at 15:11, top bits zero
   assign irq_word = irq_q | {16'h0, gpio_intr, ext_intr_in, usb_intr, i2cm_intr, 11'h0};

   assign irq_lines = irq_word[15:0];
   assign soft_irq  = irq_word[16];
   assign user_irq  = irq_word[19:17];

   assign fuse_mhartid = fuse_q;

   // Soft reset fan-out
   assign cpu_intf_rst_n = cfg1_q[0];
   assign qspim_rst_n    = cfg1_q[1];
   assign sspim_rst_n    = cfg1_q[2];
   assign uart_rst_n     = cfg1_q[3];
   assign i2cm_rst_n     = cfg1_q[4];
   assign usb_rst_n      = cfg1_q[5];
   assign cpu_core_rst_n = cfg1_q[9:8];   // One per core

   assign cfg_pulse_1us       = cfg2_q[9:0];
   assign cfg_riscv_debug_sel = cfg2_q[31:30];

   always_comb
   begin
      case (reg_idx)
         REG_CHIP_ID:   rdata = CHIP_ID_VALUE;
         REG_FUSE:      rdata = fuse_q;
         REG_GLBL_CFG1: rdata = cfg1_q;
         REG_GLBL_CFG2: rdata = cfg2_q;
         REG_IRQ:       rdata = irq_word;
         default:       rdata = '0;
      endcase
   end

endmodule

// File: rtl/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs import pinmux_pkg::*;
(
   input  logic      mclk,
   input  logic      h_reset_n,
   input  logic      wr_en,
   input  reg_idx_t  reg_idx,
   input  reg_data_t wdata,
   input  reg_be_t   be,
   input  gpio_vec_t gpio_in_data,     // Async pad inputs
   input  gpio_vec_t gpio_int_event,   // From GPIO control block
   output reg_data_t rdata,
   output gpio_vec_t cfg_gpio_out_data,
   output gpio_vec_t cfg_gpio_data_in,
   output gpio_vec_t cfg_gpio_dir_sel,
   output gpio_vec_t cfg_gpio_out_type,
   output gpio_vec_t cfg_gpio_posedge_int_sel,
   output gpio_vec_t cfg_gpio_negedge_int_sel,
   output gpio_vec_t gpio_prev_indata,
   output logic      gpio_intr
);

   gpio_vec_t in_s1;
   gpio_vec_t in_s2;
   gpio_vec_t in_s3;
   gpio_vec_t out_q;
   gpio_vec_t dir_q;
   gpio_vec_t type_q;
   gpio_vec_t mask_q;
   gpio_vec_t pos_q;
   gpio_vec_t neg_q;
   gpio_vec_t int_sts_q;
   gpio_vec_t int_sts_nxt;

   // ------------------------------
   // Input synchroniser
   // ------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         in_s1 <= '0;
         in_s2 <= '0;
         in_s3 <= '0;
      end
      else
      begin
         in_s1 <= gpio_in_data;
         in_s2 <= in_s1;
         in_s3 <= in_s2;       // Readback stage
      end
   end

   assign cfg_gpio_data_in = in_s3;
   assign gpio_prev_indata = in_s2;  // For edge detect downstream

   // ------------------------------
   // Config and mask registers
   // ------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         out_q  <= '0;
         dir_q  <= '0;
         type_q <= '0;
         mask_q <= '0;
         pos_q  <= '0;
         neg_q  <= '0;
      end
      else if (wr_en)
      begin
         case (reg_idx)
            REG_GPIO_OUT:      out_q  <= be_merge(out_q, wdata, be);
            REG_GPIO_DIR:      dir_q  <= be_merge(dir_q, wdata, be);
            REG_GPIO_TYPE:     type_q <= be_merge(type_q, wdata, be);
            REG_GPIO_INT_MASK: mask_q <= be_merge(mask_q, wdata, be);
            REG_GPIO_POS_SEL:  pos_q  <= be_merge(pos_q, wdata, be);
            REG_GPIO_NEG_SEL:  neg_q  <= be_merge(neg_q, wdata, be);
            default:           ;
         endcase
      end
   end

   assign cfg_gpio_out_data        = out_q;
   assign cfg_gpio_dir_sel         = dir_q;
   assign cfg_gpio_out_type        = type_q;
   assign cfg_gpio_posedge_int_sel = pos_q;
   assign cfg_gpio_negedge_int_sel = neg_q;

   // ------------------------------
   // Interrupt status
   // ------------------------------
   // Per lane: W1C, else W1S, then events OR in on top
   always_comb
   begin
      int_sts_nxt = int_sts_q;
      for (int i = 0; i < 4; i++)
      begin
         if (wr_en && be[i] && reg_idx == REG_GPIO_INT_CLR)
            int_sts_nxt[i*8 +: 8] = int_sts_q[i*8 +: 8] & ~wdata[i*8 +: 8];
         else if (wr_en && be[i] && reg_idx == REG_GPIO_INT_SET)
            int_sts_nxt[i*8 +: 8] = int_sts_q[i*8 +: 8] | wdata[i*8 +: 8];
      end
      int_sts_nxt = int_sts_nxt | gpio_int_event;   // Event beats clear
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_sts_q <= '0;
      else
         int_sts_q <= int_sts_nxt;
   end

   assign gpio_intr = |(int_sts_q & mask_q);   // To the IRQ register

   always_comb
   begin
      case (reg_idx)
         REG_GPIO_IN:       rdata = in_s3;
         REG_GPIO_OUT:      rdata = out_q;
         REG_GPIO_DIR:      rdata = dir_q;
         REG_GPIO_TYPE:     rdata = type_q;
         REG_GPIO_INT_CLR,
         REG_GPIO_INT_SET:  rdata = int_sts_q;   // Both aliases read status
         REG_GPIO_INT_MASK: rdata = mask_q;
         REG_GPIO_POS_SEL:  rdata = pos_q;
         REG_GPIO_NEG_SEL:  rdata = neg_q;
         default:           rdata = '0;
      endcase
   end

endmodule

// File: rtl/bist_ser_port.sv
`timescale 1ns/1ps

module bist_ser_port import pinmux_pkg::*;
(
   input  logic      mclk,
   input  logic      h_reset_n,
   input  logic      wr_en,
   input  logic      rd_en,
   input  logic      req_pedge,   // First cycle of a new request
   input  reg_idx_t  reg_idx,
   input  reg_data_t wdata,
   input  reg_be_t   be,
   input  logic      bist_sdo,    // Chain output
   output reg_data_t rdata,
   output logic      ser_sel,
   output logic      ser_ack,
   output logic      bist_en,
   output logic      bist_run,
   output logic      bist_load,
   output logic      bist_sdi,
   output logic      bist_shift
);

   reg_data_t                     ctrl_q;
   reg_data_t                     shift_q;
   logic [$clog2(SER_BITS)-1:0]   shift_cnt;
   ser_state_t                    state;

   // BIST control register
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         ctrl_q <= '0;
      else if (wr_en && reg_idx == REG_BIST_CTRL)
         ctrl_q <= be_merge(ctrl_q, wdata, be);
   end

   assign bist_en   = ctrl_q[0];
   assign bist_run  = ctrl_q[1];
   assign bist_load = ctrl_q[2];

   assign ser_sel = (wr_en && reg_idx == REG_SER_WR) || (rd_en && reg_idx == REG_SER_RD);

   // ------------------------------
   // Serial shift engine
   // ------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         state     <= SER_IDLE;
         shift_cnt <= '0;
         shift_q   <= '0;
      end
      else
      begin
         case (state)
            SER_IDLE:
            begin
               if (req_pedge && ser_sel)
               begin
                  if (wr_en)
                     shift_q <= wdata;   // Read keeps current content
                  shift_cnt <= '0;
                  state     <= SER_SHIFT;
               end
            end
            SER_SHIFT:
            begin
               shift_q   <= {bist_sdo, shift_q[SER_BITS-1:1]};  // LSB out, sdo in at top
               shift_cnt <= shift_cnt + 1'b1;
               if (shift_cnt == $bits(shift_cnt)'(SER_BITS - 1))
                  state <= SER_DONE;
            end
            default:
               state <= SER_IDLE;     // SER_DONE, one cycle
         endcase
      end
   end

   assign bist_shift = (state == SER_SHIFT);
   assign bist_sdi   = shift_q[0];
   assign ser_ack    = (state == SER_DONE);

   always_comb
   begin
      case (reg_idx)
         REG_BIST_CTRL:         rdata = ctrl_q;
         REG_SER_WR,
         REG_SER_RD:            rdata = shift_q;   // Last shifted-in word
         default:               rdata = '0;
      endcase
   end

endmodule

// File: rtl/pinmux_reg.sv
`timescale 1ns/1ps

module pinmux_reg import pinmux_pkg::*;
(
   input  logic        mclk,
   input  logic        h_reset_n,

   // Register bus
   input  logic        reg_cs,
   input  logic        reg_wr,
   input  reg_addr_t   reg_addr,
   input  reg_data_t   reg_wdata,
   input  reg_be_t     reg_be,
   output reg_data_t   reg_rdata,
   output logic        reg_ack,

   // Soft resets
   output core_rst_t   cpu_core_rst_n,
   output logic        cpu_intf_rst_n,
   output logic        qspim_rst_n,
   output logic        sspim_rst_n,
   output logic        uart_rst_n,
   output logic        i2cm_rst_n,
   output logic        usb_rst_n,

   // RISC-V config and interrupts
   input  logic [1:0]  ext_intr_in,
   input  logic        usb_intr,
   input  logic        i2cm_intr,
   output reg_data_t   fuse_mhartid,
   output logic [15:0] irq_lines,
   output logic        soft_irq,
   output logic [2:0]  user_irq,
   output pulse_cnt_t  cfg_pulse_1us,
   output logic [1:0]  cfg_riscv_debug_sel,

   // GPIO
   input  gpio_vec_t   gpio_in_data,
   input  gpio_vec_t   gpio_int_event,
   output gpio_vec_t   cfg_gpio_out_data,
   output gpio_vec_t   cfg_gpio_data_in,
   output gpio_vec_t   cfg_gpio_dir_sel,
   output gpio_vec_t   cfg_gpio_out_type,
   output gpio_vec_t   cfg_gpio_posedge_int_sel,
   output gpio_vec_t   cfg_gpio_negedge_int_sel,
   output gpio_vec_t   gpio_prev_indata,

   // BIST
   output logic        bist_en,
   output logic        bist_run,
   output logic        bist_load,
   output logic        bist_sdi,
   output logic        bist_shift,
   input  logic        bist_sdo
);

   logic      wr_en;
   logic      rd_en;
   logic      req_pedge;
   reg_idx_t  reg_idx;
   reg_data_t wdata;
   reg_be_t   be;
   reg_data_t glbl_rdata;
   reg_data_t gpio_rdata;
   reg_data_t ser_rdata;
   logic      ser_sel;
   logic      ser_ack;
   logic      gpio_intr;

   reg_bus_slave u_bus
   (
      .mclk       (mclk),
      .h_reset_n  (h_reset_n),
      .reg_cs     (reg_cs),
      .reg_wr     (reg_wr),
      .reg_addr   (reg_addr),
      .reg_wdata  (reg_wdata),
      .reg_be     (reg_be),
      .reg_rdata  (reg_rdata),
      .reg_ack    (reg_ack),
      .glbl_rdata (glbl_rdata),
      .gpio_rdata (gpio_rdata),
      .ser_rdata  (ser_rdata),
      .ser_sel    (ser_sel),
      .ser_ack    (ser_ack),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .req_pedge  (req_pedge),
      .reg_idx    (reg_idx),
      .wdata      (wdata),
      .be         (be)
   );

   glbl_cfg_regs u_glbl
   (
      .mclk                (mclk),
      .h_reset_n           (h_reset_n),
      .wr_en               (wr_en),
      .reg_idx             (reg_idx),
      .wdata               (wdata),
      .be                  (be),
      .gpio_intr           (gpio_intr),
      .usb_intr            (usb_intr),
      .i2cm_intr           (i2cm_intr),
      .ext_intr_in         (ext_intr_in),
      .rdata               (glbl_rdata),
      .fuse_mhartid        (fuse_mhartid),
      .cpu_core_rst_n      (cpu_core_rst_n),
      .cpu_intf_rst_n      (cpu_intf_rst_n),
      .qspim_rst_n         (qspim_rst_n),
      .sspim_rst_n         (sspim_rst_n),
      .uart_rst_n          (uart_rst_n),
      .i2cm_rst_n          (i2cm_rst_n),
      .usb_rst_n           (usb_rst_n),
      .cfg_pulse_1us       (cfg_pulse_1us),
      .cfg_riscv_debug_sel (cfg_riscv_debug_sel),
      .irq_lines           (irq_lines),
      .soft_irq            (soft_irq),
      .user_irq            (user_irq)
   );

   gpio_regs u_gpio
   (
      .mclk                     (mclk),
      .h_reset_n                (h_reset_n),
      .wr_en                    (wr_en),
      .reg_idx                  (reg_idx),
      .wdata                    (wdata),
      .be                       (be),
      .gpio_in_data             (gpio_in_data),
      .gpio_int_event           (gpio_int_event),
      .rdata                    (gpio_rdata),
      .cfg_gpio_out_data        (cfg_gpio_out_data),
      .cfg_gpio_data_in         (cfg_gpio_data_in),
      .cfg_gpio_dir_sel         (cfg_gpio_dir_sel),
      .cfg_gpio_out_type        (cfg_gpio_out_type),
      .cfg_gpio_posedge_int_sel (cfg_gpio_posedge_int_sel),
      .cfg_gpio_negedge_int_sel (cfg_gpio_negedge_int_sel),
      .gpio_prev_indata         (gpio_prev_indata),
      .gpio_intr                (gpio_intr)
   );

   bist_ser_port u_bist
   (
      .mclk       (mclk),
      .h_reset_n  (h_reset_n),
      .wr_en      (wr_en),
      .rd_en      (rd_en),
      .req_pedge  (req_pedge),
      .reg_idx    (reg_idx),
      .wdata      (wdata),
      .be         (be),
      .bist_sdo   (bist_sdo),
      .rdata      (ser_rdata),
      .ser_sel    (ser_sel),
      .ser_ack    (ser_ack),
      .bist_en    (bist_en),
      .bist_run   (bist_run),
      .bist_load  (bist_load),
      .bist_sdi   (bist_sdi),
      .bist_shift (bist_shift)
   );

endmodule

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen
(
   output logic mclk,
   output logic h_reset_n
);

   localparam int CLK_PERIOD = 100;   // ns
   localparam int RST_CYCLES = 8;

   initial
   begin
      mclk = 1'b0;
      forever #(CLK_PERIOD / 2) mclk = ~mclk;
   end

   // Reset low for the first eight edges
   initial
   begin
      h_reset_n = 1'b0;
      repeat (RST_CYCLES) @(posedge mclk);
      h_reset_n <= 1'b1;
   end

endmodule

// File: tests/pinmux_assertions.sv
`timescale 1ns/1ps

module pinmux_assertions
(
   input logic mclk,
   input logic h_reset_n,
   input logic reg_ack,
   input logic ser_ack,
   input logic bist_shift
);

   // Acknowledge is a single-cycle pulse
   a_ack_pulse: assert property (@(posedge mclk) disable iff (!h_reset_n)
      reg_ack |=> !reg_ack)
      else $error("reg_ack high for two cycles in a row");

   a_ack_in_reset: assert property (@(posedge mclk)
      !h_reset_n |-> !reg_ack)
      else $error("reg_ack high during reset");

   // Shift done only after the last shift cycle
   a_shift_vs_ack: assert property (@(posedge mclk) disable iff (!h_reset_n)
      !(bist_shift && ser_ack))
      else $error("bist_shift and ser_ack high together");

endmodule

bind pinmux_reg pinmux_assertions pinmux_assertions_i
(
   .mclk       (mclk),
   .h_reset_n  (h_reset_n),
   .reg_ack    (reg_ack),
   .ser_ack    (ser_ack),
   .bist_shift (bist_shift)
);

// File: tests/tb_pinmux_reg.sv
`timescale 1ns/1ps

module tb_pinmux_reg import pinmux_pkg::*;
();

   localparam int        NUM_ACC  = 160;   // Upper bound on bus accesses
   localparam longint    WD_LIMIT = longint'(NUM_ACC) * (SER_BITS + 10) * 100 * 2;
   localparam reg_data_t IRQ_RW   = 32'h000F_07FF;   // Writable IRQ bits

   logic       mclk;
   logic       h_reset_n;
   logic       reg_cs;
   logic       reg_wr;
   reg_addr_t  reg_addr;
   reg_data_t  reg_wdata;
   reg_be_t    reg_be;
   reg_data_t  reg_rdata;
   logic       reg_ack;
   core_rst_t  cpu_core_rst_n;
   logic       cpu_intf_rst_n, qspim_rst_n, sspim_rst_n;
   logic       uart_rst_n, i2cm_rst_n, usb_rst_n;
   logic [1:0] ext_intr_in;
   logic       usb_intr;
   logic       i2cm_intr;
   reg_data_t  fuse_mhartid;
   logic [15:0] irq_lines;
   logic       soft_irq;
   logic [2:0] user_irq;
   pulse_cnt_t cfg_pulse_1us;
   logic [1:0] cfg_riscv_debug_sel;
   gpio_vec_t  gpio_in_data, gpio_int_event;
   gpio_vec_t  cfg_gpio_out_data, cfg_gpio_data_in, cfg_gpio_dir_sel, cfg_gpio_out_type;
   gpio_vec_t  cfg_gpio_posedge_int_sel, cfg_gpio_negedge_int_sel, gpio_prev_indata;
   logic       bist_en, bist_run, bist_load, bist_sdi, bist_shift;
   logic       bist_sdo;

   reg_data_t  shadow [0:31];              // Register model, status at index 9
   reg_data_t  chain   = 32'h3C5A_96E1;    // External shift chain
   reg_data_t  chain_sh;                   // Expected chain content
   reg_data_t  sreg_sh;                    // Expected engine shift register
   logic [31:0] rng    = 32'h8cd5_3d2d;
   bit         acc_chk_q [$];              // Per access, check rdata or not
   reg_data_t  acc_exp_q [$];
   int         chk_cnt = 0;
   int         err_cnt = 0;

   tb_clk_gen clk_gen_i (.mclk(mclk), .h_reset_n(h_reset_n));

   pinmux_reg pinmux_reg_i (.*);

   // Chain model, LSB out, sdi in at top
   assign bist_sdo = chain[0];
   always @(posedge mclk)
   begin
      if (bist_shift)
         chain <= {bist_sdi, chain[31:1]};
   end

   // ------------------------------
   // Random, model, reference
   // ------------------------------
   function automatic logic [31:0] rand32();
      logic [31:0] x;
      x = rng;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng = x;
      return x;
   endfunction

   task automatic model_write(input reg_idx_t idx, input reg_data_t d, input reg_be_t b);
      reg_data_t lane;
      lane = {{8{b[3]}}, {8{b[2]}}, {8{b[1]}}, {8{b[0]}}};
      case (idx)
         REG_GPIO_INT_CLR: shadow[9] = shadow[9] & ~(d & lane);   // W1C
         REG_GPIO_INT_SET: shadow[9] = shadow[9] | (d & lane);    // W1S
         REG_IRQ:          shadow[8] = ((shadow[8] & ~lane) | (d & lane)) & IRQ_RW;
         REG_FUSE, REG_GLBL_CFG1, REG_GLBL_CFG2, REG_GPIO_OUT, REG_GPIO_DIR,
         REG_GPIO_TYPE, REG_GPIO_INT_MASK, REG_GPIO_POS_SEL, REG_GPIO_NEG_SEL,
         REG_BIST_CTRL:    shadow[idx] = (shadow[idx] & ~lane) | (d & lane);
         default:          ;   // Read-only or dropped
      endcase
   endtask

   function automatic reg_data_t exp_read(input reg_idx_t idx, input reg_data_t sh [0:31]);
      logic intr;
      intr = |(sh[9] & sh[11]);   // Status AND mask
      case (idx)
         REG_CHIP_ID:      return CHIP_ID_VALUE;
         REG_IRQ:          return (sh[8] & IRQ_RW) |
                                  {16'h0, intr, ext_intr_in, usb_intr, i2cm_intr, 11'h0};
         REG_GPIO_INT_CLR,
         REG_GPIO_INT_SET: return sh[9];
         REG_FUSE, REG_GLBL_CFG1, REG_GLBL_CFG2, REG_GPIO_IN, REG_GPIO_OUT,
         REG_GPIO_DIR, REG_GPIO_TYPE, REG_GPIO_INT_MASK, REG_GPIO_POS_SEL,
         REG_GPIO_NEG_SEL, REG_BIST_CTRL:
                           return sh[idx];
         default:          return '0;
      endcase
   endfunction

   // ------------------------------
   // Compare tasks
   // ------------------------------
   task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      end
   endtask

   task automatic check_gpio(input string name, input gpio_vec_t got, input gpio_vec_t exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      chk_cnt++;
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
      end
   endtask

   // Every acknowledge is matched to its queued access
   always @(negedge mclk)
   begin : compare_acks
      bit        chk;
      reg_data_t exp;
      if (reg_ack)
      begin
         if (acc_chk_q.size() == 0)
         begin
            err_cnt++;
            $display("Acknowledge seen with no access pending at %0t", $time);
         end
         else
         begin
            chk = acc_chk_q.pop_front();
            exp = acc_exp_q.pop_front();
            if (chk)
               check_data("reg_rdata", reg_rdata, exp);
         end
      end
   end

   // ------------------------------
   // Bus tasks
   // ------------------------------
   task automatic bus_access(input bit wr, input reg_idx_t idx, input reg_data_t d,
                             input reg_be_t b, input bit chk, input reg_data_t exp);
      acc_chk_q.push_back(chk);
      acc_exp_q.push_back(exp);
      @(posedge mclk);
      reg_cs    <= 1'b1;
      reg_wr    <= wr;
      reg_addr  <= {1'b0, idx, 2'b00};
      reg_wdata <= d;
      reg_be    <= b;
      do
         @(negedge mclk);
      while (!reg_ack);
      @(posedge mclk);
      reg_cs <= 1'b0;             // Idle at least one cycle
      reg_wr <= 1'b0;
   endtask

   task automatic bus_write(input reg_idx_t idx, input reg_data_t d, input reg_be_t b);
      model_write(idx, d, b);
      bus_access(1'b1, idx, d, b, 1'b0, '0);
   endtask

   task automatic bus_read(input reg_idx_t idx);
      bus_access(1'b0, idx, '0, 4'hF, 1'b1, exp_read(idx, shadow));
   endtask

   // Ack data is the chain's old word
   task automatic ser_write(input reg_data_t x);
      reg_data_t old;
      old      = chain_sh;
      chain_sh = x;
      sreg_sh  = old;
      bus_access(1'b1, REG_SER_WR, x, 4'hF, 1'b1, old);
      check_data("chain", chain, x);
   endtask

   task automatic ser_read();
      reg_data_t old;
      old      = chain_sh;
      chain_sh = sreg_sh;
      sreg_sh  = old;
      bus_access(1'b0, REG_SER_RD, '0, 4'hF, 1'b1, old);
   endtask

   task automatic check_outputs();
      reg_data_t irq;
      irq = exp_read(REG_IRQ, shadow);
      check_data("fuse_mhartid", fuse_mhartid, shadow[REG_FUSE]);
      check_bit("cpu_intf_rst_n", cpu_intf_rst_n, shadow[REG_GLBL_CFG1][0]);
      check_bit("qspim_rst_n", qspim_rst_n, shadow[REG_GLBL_CFG1][1]);
      check_bit("sspim_rst_n", sspim_rst_n, shadow[REG_GLBL_CFG1][2]);
      check_bit("uart_rst_n", uart_rst_n, shadow[REG_GLBL_CFG1][3]);
      check_bit("i2cm_rst_n", i2cm_rst_n, shadow[REG_GLBL_CFG1][4]);
      check_bit("usb_rst_n", usb_rst_n, shadow[REG_GLBL_CFG1][5]);
      check_data("cpu_core_rst_n", {30'h0, cpu_core_rst_n},
                 {30'h0, shadow[REG_GLBL_CFG1][9:8]});
      check_data("cfg_pulse_1us", {22'h0, cfg_pulse_1us}, {22'h0, shadow[REG_GLBL_CFG2][9:0]});
      check_data("cfg_riscv_debug_sel", {30'h0, cfg_riscv_debug_sel},
                 {30'h0, shadow[REG_GLBL_CFG2][31:30]});
      check_data("irq_lines", {16'h0, irq_lines}, {16'h0, irq[15:0]});
      check_bit("soft_irq", soft_irq, irq[16]);
      check_data("user_irq", {29'h0, user_irq}, {29'h0, irq[19:17]});
      check_gpio("cfg_gpio_out_data", cfg_gpio_out_data, shadow[REG_GPIO_OUT]);
      check_gpio("cfg_gpio_dir_sel", cfg_gpio_dir_sel, shadow[REG_GPIO_DIR]);
      check_gpio("cfg_gpio_out_type", cfg_gpio_out_type, shadow[REG_GPIO_TYPE]);
      check_gpio("cfg_gpio_posedge_int_sel", cfg_gpio_posedge_int_sel, shadow[REG_GPIO_POS_SEL]);
      check_gpio("cfg_gpio_negedge_int_sel", cfg_gpio_negedge_int_sel, shadow[REG_GPIO_NEG_SEL]);
      check_bit("bist_en", bist_en, shadow[REG_BIST_CTRL][0]);
      check_bit("bist_run", bist_run, shadow[REG_BIST_CTRL][1]);
      check_bit("bist_load", bist_load, shadow[REG_BIST_CTRL][2]);
   endtask

   // ------------------------------
   // Main sequence
   // ------------------------------
   initial
   begin : main_seq
      reg_idx_t  wr_idx [11];
      reg_data_t d;
      reg_data_t hold;
      logic [31:0] r;
      wr_idx = '{REG_FUSE, REG_GLBL_CFG1, REG_GLBL_CFG2, REG_GPIO_OUT, REG_GPIO_DIR,
                 REG_GPIO_TYPE, REG_IRQ, REG_GPIO_INT_MASK, REG_GPIO_POS_SEL,
                 REG_GPIO_NEG_SEL, REG_BIST_CTRL};
      reg_cs = 1'b0;
      reg_wr = 1'b0;
      reg_addr = '0;
      reg_wdata = '0;
      reg_be = '0;
      ext_intr_in = '0;
      usb_intr = 1'b0;
      i2cm_intr = 1'b0;
      gpio_in_data = '0;
      gpio_int_event = '0;
      foreach (shadow[i])
         shadow[i] = '0;
      shadow[REG_FUSE] = FUSE_RESET;
      chain_sh = chain;
      sreg_sh  = '0;
      @(posedge h_reset_n);
      repeat (2) @(posedge mclk);

      // Reset state
      check_data("reg_rdata", reg_rdata, '0);
      check_bit("reg_ack", reg_ack, 1'b0);
      for (int i = 0; i < 30; i++)
         bus_read(reg_idx_t'(i));
      check_outputs();
      check_bit("bist_shift", bist_shift, 1'b0);

      // Byte-enabled writes, read back
      for (int n = 0; n < 3; n++)
      begin
         r = rand32();
         @(posedge mclk);
         ext_intr_in <= r[1:0];           // Live IRQ inputs
         usb_intr    <= r[2];
         i2cm_intr   <= r[3];
         @(posedge mclk);
         foreach (wr_idx[k])
         begin
            d = rand32();
            r = rand32();
            bus_write(wr_idx[k], d, r[3:0]);
            check_outputs();
            bus_read(wr_idx[k]);
         end
      end
      bus_write(5'd20, rand32(), 4'hF);   // Dropped address
      bus_read(5'd20);
      bus_read(5'd14);

      // GPIO input sync
      for (int n = 0; n < 2; n++)
      begin
         @(posedge mclk);
         d = rand32();
         gpio_in_data <= d;
         shadow[REG_GPIO_IN] = d;
         repeat (5) @(posedge mclk);
         bus_read(REG_GPIO_IN);
         check_gpio("cfg_gpio_data_in", cfg_gpio_data_in, d);
         check_gpio("gpio_prev_indata", gpio_prev_indata, d);
      end

      // ------------------------------
      // Interrupt status
      // ------------------------------
      bus_write(REG_GPIO_INT_MASK, '0, 4'hF);
      bus_write(REG_GPIO_INT_CLR, 32'hFFFF_FFFF, 4'hF);
      @(posedge mclk);
      gpio_int_event <= 32'h0000_8101;    // One-cycle event pulse
      @(posedge mclk);
      gpio_int_event <= '0;
      shadow[9] = shadow[9] | 32'h0000_8101;
      bus_write(REG_GPIO_INT_SET, 32'h0F00_0000, 4'hF);
      bus_read(REG_GPIO_INT_CLR);
      bus_write(REG_GPIO_INT_CLR, 32'hFFFF_FFFF, 4'b1001);   // Lanes 0 and 3 only
      bus_read(REG_GPIO_INT_SET);
      hold = 32'h0000_0100;
      @(posedge mclk);
      gpio_int_event <= hold;             // Held through the clear
      bus_write(REG_GPIO_INT_CLR, 32'h0000_FF00, 4'hF);
      shadow[9] = shadow[9] | hold;
      gpio_int_event <= '0;               // Gone before the next edge
      bus_read(REG_GPIO_INT_CLR);
      bus_write(REG_GPIO_INT_MASK, 32'h0000_0100, 4'hF);
      check_bit("irq_lines[15]", irq_lines[15], |(shadow[9] & shadow[11]));
      bus_read(REG_IRQ);
      bus_write(REG_GPIO_INT_MASK, 32'h0000_0001, 4'hF);
      check_bit("irq_lines[15]", irq_lines[15], |(shadow[9] & shadow[11]));
      bus_read(REG_IRQ);

      // BIST serial port
      for (int n = 0; n < 3; n++)
      begin
         ser_write(rand32());
         ser_read();
      end

      repeat (2) @(posedge mclk);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(WD_LIMIT);
      $display("Timeout: the run did not finish within %0d ns", WD_LIMIT);
      $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
      $display("TB FAILED");
      $finish;
   end

endmodule

// File: build.f
rtl/pinmux_pkg.sv
rtl/reg_bus_slave.sv
rtl/glbl_cfg_regs.sv
rtl/gpio_regs.sv
rtl/bist_ser_port.sv
rtl/pinmux_reg.sv
tests/tb_clk_gen.sv
tests/pinmux_assertions.sv
tests/tb_pinmux_reg.sv

// File: run.sh
#!/bin/sh
# Compile and run with Verilator, then search the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module tb_pinmux_reg -o tb_sim > build.log 2>&1 \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "TB PASSED" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
